//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f fetchCore.f --top-module fetchCoreTb

sim:
	verilator --binary --timing --assert -f fetchCore.f --top-module fetchCoreTb -o simTb
	@out="$$(./obj_dir/simTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- fetchCore.f
+incdir+src
src/fetchPkg.sv
src/pcGen.sv
src/fetchStage.sv
src/packetQueue.sv
src/memArbiter.sv
src/fetchCore.sv
tests/fetchCoreTb.sv

//--- src/fetchCore.sv
`timescale 1ns/1ps
`include "fetchCore_cfg.svh"

module fetchCore
	import fetchPkg::*;
(
	input logic clk,
	input logic rst,

	// fetch control
	input logic en,
	input logic redirect,
	input pc_t redirectPc,

	// instruction memory
	output logic [`INSTR_ADDR_W-1:0] instrAddr,
	output logic instrReadEnable,
	input packet_t instrRaw,

	// consumer side of the packet queue
	output logic pktValid,
	output pc_t pktPc,
	output packet_t pktData,
	input logic pktTake,

	// instruction cache fill requester
	input logic fillCe,
	input logic fillWe,
	input logic [`MC_SRAM_W-1:0] fillSramAddr,
	input logic [`MC_EXT_W-1:0] fillExtAddr,
	output logic fillBusy,

	// data cache requester
	input logic dataCe,
	input logic dataWe,
	input logic [`MC_SRAM_W-1:0] dataSramAddr,
	input logic [`MC_EXT_W-1:0] dataExtAddr,
	output logic dataBusy,

	// memory controller port
	output logic mcCe,
	output logic mcWe,
	output logic [`MC_SRAM_W-1:0] mcSramAddr,
	output logic [`MC_EXT_W-1:0] mcExtAddr,
	output mcOwner_t mcCacheId,
	input logic mcBusy
);

	logic fetchEn;
	pc_t pc;

	logic push;
	pc_t pushPc;
	packet_t pushData;

	// memory is addressed by packet, so the byte offset is dropped
	assign instrAddr = pc[`ADDR_W-1 -: `INSTR_ADDR_W];
	assign instrReadEnable = fetchEn;

	pcGen pcGenInst (
		.clk(clk),
		.rst(rst),
		.fetchEn(fetchEn),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.pc(pc)
	);

	fetchStage fetchStageInst (
		.clk(clk),
		.rst(rst),
		.fetchEn(fetchEn),
		.redirect(redirect),
		.pc(pc),
		.instrRaw(instrRaw),
		.push(push),
		.pushPc(pushPc),
		.pushData(pushData)
	);

	// the queue also owns the fetch enable through its full state
	packetQueue packetQueueInst (
		.clk(clk),
		.rst(rst),
		.en(en),
		.flush(redirect),
		.push(push),
		.pushPc(pushPc),
		.pushData(pushData),
		.take(pktTake),
		.fetchEn(fetchEn),
		.valid(pktValid),
		.outPc(pktPc),
		.outData(pktData)
	);

	memArbiter memArbiterInst (
		.fillCe(fillCe),
		.fillWe(fillWe),
		.fillSramAddr(fillSramAddr),
		.fillExtAddr(fillExtAddr),
		.dataCe(dataCe),
		.dataWe(dataWe),
		.dataSramAddr(dataSramAddr),
		.dataExtAddr(dataExtAddr),
		.mcBusy(mcBusy),
		.mcCe(mcCe),
		.mcWe(mcWe),
		.mcSramAddr(mcSramAddr),
		.mcExtAddr(mcExtAddr),
		.mcCacheId(mcCacheId),
		.fillBusy(fillBusy),
		.dataBusy(dataBusy)
	);

endmodule

//--- src/fetchCore_cfg.svh
`ifndef FETCHCORE_CFG_SVH
`define FETCHCORE_CFG_SVH

// program counter and fetch packet geometry
`define ADDR_W 32
`define PKT_W 128
`define PKT_BYTES 16

// instruction memory is addressed in whole packets
`define INSTR_ADDR_W 28

`define QUEUE_DEPTH 4
`define RESET_PC 32'h0000_1000

// memory controller request fields
`define MC_SRAM_W 10
`define MC_EXT_W 30

`endif

//--- src/fetchPkg.sv
`include "fetchCore_cfg.svh"

package fetchPkg;

	// the encoding doubles as the cache ID seen by the memory controller
	typedef enum logic [0:0] {
		OWNER_DATA = 1'b0,
		OWNER_INSTR = 1'b1
	} mcOwner_t;

	// byte address of a fetch packet
	typedef logic [`ADDR_W-1:0] pc_t;

	// one raw fetch packet, four 32-bit words
	typedef logic [`PKT_W-1:0] packet_t;

endpackage

//--- src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage
	import fetchPkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetchEn,
	input logic redirect,
	input pc_t pc,
	input packet_t instrRaw,
	output logic push,
	output pc_t pushPc,
	output packet_t pushData
);

	// stageValid[0] means an address went out in the last enabled cycle,
	// so its packet is due now
	// stageValid[1] means that packet sits in the hold register
	logic [1:0] stageValid;

	pc_t prevPc;
	packet_t heldPacket;

	logic captureHeld;

	// the first stalled cycle is the last one where instrRaw is still defined
	assign captureHeld = !fetchEn && stageValid[0] && !stageValid[1];

	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			stageValid <= 2'b00;
		end else if (fetchEn) begin
			stageValid <= 2'b01;
		end else if (captureHeld) begin
			stageValid[1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (captureHeld) begin
			heldPacket <= instrRaw;
		end
	end

	// the packet on the bus belongs to the address issued one enabled step ago
	always_ff @(posedge clk) begin
		if (fetchEn) begin
			prevPc <= pc;
		end
	end

	assign push = fetchEn && stageValid[0] && !redirect;
	assign pushPc = prevPc;
	assign pushData = stageValid[1] ? heldPacket : instrRaw;

endmodule

//--- src/memArbiter.sv
`timescale 1ns/1ps
`include "fetchCore_cfg.svh"

module memArbiter
	import fetchPkg::*;
(
	input logic fillCe,
	input logic fillWe,
	input logic [`MC_SRAM_W-1:0] fillSramAddr,
	input logic [`MC_EXT_W-1:0] fillExtAddr,
	input logic dataCe,
	input logic dataWe,
	input logic [`MC_SRAM_W-1:0] dataSramAddr,
	input logic [`MC_EXT_W-1:0] dataExtAddr,
	input logic mcBusy,
	output logic mcCe,
	output logic mcWe,
	output logic [`MC_SRAM_W-1:0] mcSramAddr,
	output logic [`MC_EXT_W-1:0] mcExtAddr,
	output mcOwner_t mcCacheId,
	output logic fillBusy,
	output logic dataBusy
);

	// instruction fills always win the port
	always_comb begin
		if (fillCe) begin
			mcCe = fillCe;
			mcWe = fillWe;
			mcSramAddr = fillSramAddr;
			mcExtAddr = fillExtAddr;
			mcCacheId = OWNER_INSTR;
		end else begin
			mcCe = dataCe;
			mcWe = dataWe;
			mcSramAddr = dataSramAddr;
			mcExtAddr = dataExtAddr;
			mcCacheId = OWNER_DATA;
		end
	end

	// each side sees the port as busy while the other side requests it
	assign fillBusy = mcBusy || dataCe;
	assign dataBusy = mcBusy || fillCe;

endmodule

//--- src/packetQueue.sv
`timescale 1ns/1ps
`include "fetchCore_cfg.svh"

module packetQueue
	import fetchPkg::*;
(
	input logic clk,
	input logic rst,
	input logic en,
	input logic flush,
	input logic push,
	input pc_t pushPc,
	input packet_t pushData,
	input logic take,
	output logic fetchEn,
	output logic valid,
	output pc_t outPc,
	output packet_t outData
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	pc_t pcMem [`QUEUE_DEPTH];
	packet_t dataMem [`QUEUE_DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;

	logic full;
	logic doPush;
	logic doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(`QUEUE_DEPTH));
	assign valid = (count != '0);

	// fetch stops as soon as every slot is taken
	assign fetchEn = en && !full;

	assign doPush = push && !full && !flush;
	assign doPop = valid && take && !flush;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) begin
			pcMem[wrPtr] <= pushPc;
			dataMem[wrPtr] <= pushData;
		end
	end

	assign outPc = pcMem[rdPtr];
	assign outData = dataMem[rdPtr];

endmodule

//--- src/pcGen.sv
`timescale 1ns/1ps
`include "fetchCore_cfg.svh"

module pcGen
	import fetchPkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetchEn,
	input logic redirect,
	input pc_t redirectPc,
	output pc_t pc
);

	// number of low address bits covered by one packet
	localparam int ALIGN_W = $clog2(`PKT_BYTES);

	pc_t alignedTarget;
	pc_t nextSeqPc;

	// redirect targets are forced onto a packet boundary
	assign alignedTarget = {redirectPc[`ADDR_W-1:ALIGN_W], {ALIGN_W{1'b0}}};

	assign nextSeqPc = pc + pc_t'(`PKT_BYTES);

	// a redirect wins even while fetch is stalled
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= pc_t'(`RESET_PC);
		end else if (redirect) begin
			pc <= alignedTarget;
		end else if (fetchEn) begin
			pc <= nextSeqPc;
		end
	end

endmodule

//--- tests/fetchCoreTb.sv
`timescale 1ns/1ps
`include "fetchCore_cfg.svh"

module fetchCoreTb
	import fetchPkg::*;
;

	localparam int CYCLE_NS = 100;
	localparam int BUDGET_CYCLES = 4 + 60 + 166 + 62 + 32 + 50;

	logic clk = 1'b0;
	logic rst;
	logic en;
	logic redirect;
	pc_t redirectPc;
	logic [`INSTR_ADDR_W-1:0] instrAddr;
	logic instrReadEnable;
	packet_t instrRaw;
	logic pktValid;
	pc_t pktPc;
	packet_t pktData;
	logic pktTake;
	logic fillCe;
	logic fillWe;
	logic [`MC_SRAM_W-1:0] fillSramAddr;
	logic [`MC_EXT_W-1:0] fillExtAddr;
	logic fillBusy;
	logic dataCe;
	logic dataWe;
	logic [`MC_SRAM_W-1:0] dataSramAddr;
	logic [`MC_EXT_W-1:0] dataExtAddr;
	logic dataBusy;
	logic mcCe;
	logic mcWe;
	logic [`MC_SRAM_W-1:0] mcSramAddr;
	logic [`MC_EXT_W-1:0] mcExtAddr;
	mcOwner_t mcCacheId;
	logic mcBusy;

	logic [31:0] seed = 32'h03e73299;
	logic randTake = 1'b0;
	logic memEn = 1'b0;
	logic [`INSTR_ADDR_W-1:0] memAddr = '0;
	pc_t expPc;
	int popCount = 0;
	int errors = 0;
	int passCount = 0;
	int failCount = 0;
	logic prevRedirect = 1'b0;
	logic prevEnLow = 1'b0;
	logic prevIdle = 1'b0;
	logic [`INSTR_ADDR_W-1:0] prevAddr = '0;

	fetchCore dut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// word i of a packet is its byte address plus i
	function automatic packet_t packetWords(input pc_t a);
		return {a + 32'd3, a + 32'd2, a + 32'd1, a};
	endfunction

	initial begin
		forever #(CYCLE_NS / 2) clk = ~clk;
	end

	// the memory answers an enabled address in the following cycle
	always @(posedge clk) begin
		memEn = instrReadEnable;
		memAddr = instrAddr;
	end

	always @(negedge clk) begin
		seed = xorshift(seed);
		instrRaw = memEn ? packetWords({memAddr, 4'b0000}) : {4{seed}};
		fillCe = seed[0];
		dataCe = seed[1];
		fillWe = seed[2];
		dataWe = seed[3];
		mcBusy = seed[4];
		if (randTake) begin
			pktTake = seed[5];
		end
		fillSramAddr = seed[15:6];
		dataSramAddr = seed[25:16];
		seed = xorshift(seed);
		fillExtAddr = seed[29:0];
		dataExtAddr = {seed[15:0], seed[31:18]};
	end

	// expected consumer order, following pops and redirects
	always @(posedge clk) begin
		prevRedirect <= redirect && !rst;
		prevEnLow <= !en && !redirect && !rst;
		prevIdle <= !en && !pktValid && !redirect && !rst;
		prevAddr <= instrAddr;
		if (rst) begin
			expPc <= `RESET_PC;
		end else if (redirect) begin
			expPc <= {redirectPc[31:4], 4'b0000};
		end else if (pktValid && pktTake) begin
			expPc <= expPc + `PKT_BYTES;
			popCount <= popCount + 1;
		end
	end

	assert property (@(posedge clk) disable iff (rst) (pktValid && pktTake) |-> pktPc == expPc)
		else begin
			errors++;
			$display("** Error at %0t: pktPc expected %h, got %h", $time,
				$sampled(expPc), $sampled(pktPc));
		end
	assert property (@(posedge clk) disable iff (rst)
		(pktValid && pktTake) |-> pktData == packetWords(pktPc))
		else begin
			errors++;
			$display("** Error at %0t: pktData expected %h, got %h", $time,
				packetWords($sampled(pktPc)), $sampled(pktData));
		end
	assert property (@(posedge clk) disable iff (rst) prevRedirect |-> !pktValid)
		else begin
			errors++;
			$display("** Error at %0t: pktValid expected 0, got 1 after redirect", $time);
		end
	assert property (@(posedge clk) disable iff (rst) (en && !instrReadEnable) |-> pktValid)
		else begin
			errors++;
			$display("** Error at %0t: pktValid expected 1, got 0 while stalled", $time);
		end
	assert property (@(posedge clk) disable iff (rst) !en |-> !instrReadEnable)
		else begin
			errors++;
			$display("** Error at %0t: instrReadEnable expected 0, got 1", $time);
		end
	assert property (@(posedge clk) disable iff (rst) prevEnLow |-> instrAddr == prevAddr)
		else begin
			errors++;
			$display("** Error at %0t: instrAddr expected %h, got %h", $time,
				$sampled(prevAddr), $sampled(instrAddr));
		end
	assert property (@(posedge clk) disable iff (rst) prevIdle |-> !pktValid)
		else begin
			errors++;
			$display("** Error at %0t: pktValid expected 0, got 1 with en low", $time);
		end
	assert property (@(posedge clk) mcSramAddr == (fillCe ? fillSramAddr : dataSramAddr))
		else begin
			errors++;
			$display("** Error at %0t: mcSramAddr expected %h, got %h", $time,
				$sampled(fillCe) ? $sampled(fillSramAddr) : $sampled(dataSramAddr),
				$sampled(mcSramAddr));
		end
	assert property (@(posedge clk) mcExtAddr == (fillCe ? fillExtAddr : dataExtAddr))
		else begin
			errors++;
			$display("** Error at %0t: mcExtAddr expected %h, got %h", $time,
				$sampled(fillCe) ? $sampled(fillExtAddr) : $sampled(dataExtAddr),
				$sampled(mcExtAddr));
		end
	assert property (@(posedge clk) mcWe == (fillCe ? fillWe : dataWe))
		else begin
			errors++;
			$display("** Error at %0t: mcWe expected %b, got %b", $time,
				$sampled(fillCe) ? $sampled(fillWe) : $sampled(dataWe),
				$sampled(mcWe));
		end
	assert property (@(posedge clk) mcCe == (fillCe || dataCe))
		else begin
			errors++;
			$display("** Error at %0t: mcCe expected %b, got %b", $time,
				$sampled(fillCe || dataCe), $sampled(mcCe));
		end
	assert property (@(posedge clk) mcCacheId == (fillCe ? OWNER_INSTR : OWNER_DATA))
		else begin
			errors++;
			$display("** Error at %0t: mcCacheId expected %0d, got %0d", $time,
				$sampled(fillCe), $sampled(mcCacheId));
		end
	assert property (@(posedge clk)
		fillBusy == (mcBusy || dataCe) && dataBusy == (mcBusy || fillCe))
		else begin
			errors++;
			$display("** Error at %0t: fillBusy expected %b, got %b, dataBusy expected %b, got %b",
				$time, $sampled(mcBusy || dataCe), $sampled(fillBusy),
				$sampled(mcBusy || fillCe), $sampled(dataBusy));
		end

	task automatic waitPops(input int n, input int budget);
		int target;
		int cycles;
		target = popCount + n;
		cycles = 0;
		while (popCount < target && cycles < budget) begin
			@(negedge clk);
			cycles++;
		end
		if (popCount < target) begin
			errors++;
			$display("timed out at %0t waiting for %0d packets", $time, n);
		end
	endtask

	task automatic waitStall(input int budget);
		int cycles;
		cycles = 0;
		while (instrReadEnable && cycles < budget) begin
			@(negedge clk);
			cycles++;
		end
		if (instrReadEnable) begin
			errors++;
			$display("timed out at %0t waiting for fetch to stall on a full queue", $time);
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errors == startErrors) begin
			passCount++;
			$display("%s: pass", name);
		end else begin
			failCount++;
			$display("%s: FAIL", name);
		end
	endtask

	initial begin
		int startErrors;
		rst = 1'b1;
		en = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		pktTake = 1'b0;
		instrRaw = '0;
		fillCe = 1'b0;
		fillWe = 1'b0;
		fillSramAddr = '0;
		fillExtAddr = '0;
		dataCe = 1'b0;
		dataWe = 1'b0;
		dataSramAddr = '0;
		dataExtAddr = '0;
		mcBusy = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		startErrors = errors;
		en = 1'b1;
		pktTake = 1'b1;
		waitPops(20, 60);
		finishTest("in-order stream", startErrors);

		startErrors = errors;
		pktTake = 1'b0;
		waitStall(20);
		repeat (6) @(negedge clk);
		randTake = 1'b1;
		waitPops(30, 140);
		randTake = 1'b0;
		finishTest("back-pressure", startErrors);

		startErrors = errors;
		pktTake = 1'b1;
		redirect = 1'b1;
		redirectPc = 32'h0000_2a37;
		@(negedge clk);
		redirect = 1'b0;
		waitPops(4, 20);
		pktTake = 1'b0;
		waitStall(20);
		redirect = 1'b1;
		redirectPc = 32'h0001_00f9;
		@(negedge clk);
		redirect = 1'b0;
		pktTake = 1'b1;
		waitPops(4, 20);
		finishTest("redirect", startErrors);

		startErrors = errors;
		en = 1'b0;
		repeat (12) @(negedge clk);
		en = 1'b1;
		waitPops(3, 20);
		finishTest("fetch disable", startErrors);

		startErrors = errors;
		repeat (50) @(negedge clk);
		finishTest("memory arbiter", startErrors);

		$display("%0d passed, %0d failed", passCount, failCount);
		if (failCount == 0 && errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#((BUDGET_CYCLES + 100) * CYCLE_NS);
		$display("watchdog expired at %0t before the tests finished", $time);
		$display("tests failed");
		$finish;
	end

endmodule
